/* tb/ecc_stim.txt */
# op data chk exp_data exp_chk exp_single exp_double, all hex
# op 0 encodes and ignores chk, op 1 decodes
0 00000000 00 00000000 00 0 0
0 00000001 00 00000001 43 0 0
0 80000000 7f 80000000 26 0 0
0 00000003 00 00000003 06 0 0
0 0000000f 00 0000000f 47 0 0
0 000000ff 00 000000ff 03 0 0
0 0000ffff 00 0000ffff 1e 0 0
0 ffffffff 00 ffffffff 18 0 0
0 a5a5a5a5 00 a5a5a5a5 72 0 0
1 00000000 00 00000000 00 0 0
1 00000001 43 00000001 43 0 0
1 80000000 26 80000000 26 0 0
1 a5a5a5a5 72 a5a5a5a5 72 0 0
1 ffffffff 18 ffffffff 18 0 0
1 0000ffff 1e 0000ffff 1e 0 0
1 a5a5a5a4 72 a5a5a5a5 72 1 0
1 7fffffff 18 ffffffff 18 1 0
1 00010000 00 00000000 00 1 0
1 0000fbff 1e 0000ffff 1e 1 0
1 0000007f 03 000000ff 03 1 0
1 0000001f 47 0000000f 47 1 0
1 a5a5a5a5 73 a5a5a5a5 72 1 0
1 a5a5a5a5 52 a5a5a5a5 72 1 0
1 a5a5a5a5 32 a5a5a5a5 72 1 0
1 ffffffff 10 ffffffff 18 1 0
1 0000ffff 0e 0000ffff 1e 1 0
1 00000000 40 00000000 00 1 0
1 a5a5a5a6 72 a5a5a5a6 72 0 1
1 fffffffe 1a fffffffe 1a 0 1
1 00000000 03 00000000 03 0 1
1 80000001 03 80000001 03 0 1
1 00007ffe 1e 00007ffe 1e 0 1

/* vlog.f */
+incdir+rtl
rtl/ecc_pkg.sv
rtl/ecc_checkgen.sv
rtl/ecc_req_in.sv
rtl/ecc_engine.sv
rtl/ecc_rsp_out.sv
rtl/ecc_codec_top.sv
tb/ecc_codec_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the ECC codec testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module ecc_codec_tb -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/Vecc_codec_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
   exit 1
fi
exit 0

/* tb/ecc_codec_tb.sv */
`default_nettype none

module ecc_codec_tb;
   import ecc_pkg::*;

   localparam int CLK_PERIOD  = 100;
   localparam int DRIVE_DLY   = 10;
   localparam int RESET_CYC   = 5;
   localparam int MAX_VEC     = 64;
   localparam int CYC_PER_VEC = 20;
   localparam int DRAIN_CYC   = 20;

   logic        clk;
   logic        rst_l;
   logic        req_in;
   ecc_op_e     cmd_op;
   ecc_data_t   cmd_data;
   ecc_chk_t    cmd_chk;
   logic        ack_in;
   logic        ack_out;
   logic        req_out;
   ecc_data_t   rsp_data;
   ecc_chk_t    rsp_chk;
   logic        rsp_single_err;
   logic        rsp_double_err;

   ecc_cmd_t    stim_cmd [MAX_VEC];
   ecc_rsp_t    stim_rsp [MAX_VEC];
   ecc_rsp_t    exp_q [$];
   int          num_vec;
   int          rsp_cnt;
   int          pass_cnt;
   int          fail_cnt;
   int          err_cnt;
   logic        stim_loaded;
   logic        ack_in_prev;
   logic [31:0] rng_state;

   ecc_codec_top i_dut (
      .clk            (clk),
      .rst_l          (rst_l),
      .req_in         (req_in),
      .cmd_op         (cmd_op),
      .cmd_data       (cmd_data),
      .cmd_chk        (cmd_chk),
      .ack_in         (ack_in),
      .ack_out        (ack_out),
      .req_out        (req_out),
      .rsp_data       (rsp_data),
      .rsp_chk        (rsp_chk),
      .rsp_single_err (rsp_single_err),
      .rsp_double_err (rsp_double_err)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic check_data(input string name, input ecc_data_t got, input ecc_data_t want);
      if (got !== want) begin
         $display("Mismatch at %0t: %s expected %h got %h", $time, name, want, got);
         err_cnt++;
      end
   endtask

   task automatic check_chk(input string name, input ecc_chk_t got, input ecc_chk_t want);
      if (got !== want) begin
         $display("Mismatch at %0t: %s expected %h got %h", $time, name, want, got);
         err_cnt++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic want);
      if (got !== want) begin
         $display("Mismatch at %0t: %s expected %b got %b", $time, name, want, got);
         err_cnt++;
      end
   endtask

   task automatic expect_reset_state();
      check_flag("ack_in", ack_in, 1'b0);
      check_flag("req_out", req_out, 1'b0);
      check_data("rsp_data", rsp_data, '0);
      check_chk("rsp_chk", rsp_chk, '0);
      check_flag("rsp_single_err", rsp_single_err, 1'b0);
      check_flag("rsp_double_err", rsp_double_err, 1'b0);
   endtask

   // skips blank lines and lines starting with #
   task automatic load_stimulus();
      int          fd;
      int          n;
      string       line;
      logic [31:0] f_op, f_data, f_chk, f_edata, f_echk, f_es, f_ed;
      fd = $fopen("tb/ecc_stim.txt", "r");
      if (fd == 0) begin
         $display("could not open the stimulus file tb/ecc_stim.txt");
         err_cnt++;
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         if ($fgets(line, fd) == 0) break;
         if (line.len() == 0 || line[0] == "#") continue;
         n = $sscanf(line, "%h %h %h %h %h %h %h", f_op, f_data, f_chk, f_edata, f_echk,
                     f_es, f_ed);
         if (n <= 0) continue;
         if (n != 7 || num_vec == MAX_VEC) begin
            $display("stimulus line malformed or beyond capacity: %s", line);
            err_cnt++;
            continue;
         end
         stim_cmd[num_vec].op         = ecc_op_e'(f_op[0]);
         stim_cmd[num_vec].data       = f_data;
         stim_cmd[num_vec].chk        = f_chk[6:0];
         stim_rsp[num_vec].data       = f_edata;
         stim_rsp[num_vec].chk        = f_echk[6:0];
         stim_rsp[num_vec].single_err = f_es[0];
         stim_rsp[num_vec].double_err = f_ed[0];
         num_vec++;
      end
      $fclose(fd);
   endtask

   // sender side of the four-phase input handshake
   task automatic drive_commands();
      for (int i = 0; i < num_vec; i++) begin
         @(posedge clk);
         #(DRIVE_DLY);
         cmd_op   = stim_cmd[i].op;
         cmd_data = stim_cmd[i].data;
         cmd_chk  = stim_cmd[i].chk;
         exp_q.push_back(stim_rsp[i]);
         @(posedge clk);
         #(DRIVE_DLY);
         req_in = 1'b1;
         @(negedge clk);
         while (!ack_in) @(negedge clk);
         @(posedge clk);
         #(DRIVE_DLY);
         req_in = 1'b0;
         @(negedge clk);
         while (ack_in) @(negedge clk);
      end
   endtask

   // receiver side with a random ack delay of 0 to 7 cycles
   task automatic collect_responses();
      ecc_rsp_t want;
      int       errs;
      int       delay;
      for (int n = 0; n < num_vec; n++) begin
         @(negedge clk);
         while (!req_out) @(negedge clk);
         errs = err_cnt;
         if (exp_q.size() == 0) begin
            $display("response %0d arrived with no command pending", n);
            err_cnt++;
         end else begin
            want = exp_q.pop_front();
            check_data("rsp_data", rsp_data, want.data);
            check_chk("rsp_chk", rsp_chk, want.chk);
            check_flag("rsp_single_err", rsp_single_err, want.single_err);
            check_flag("rsp_double_err", rsp_double_err, want.double_err);
         end
         rsp_cnt++;
         if (err_cnt == errs) pass_cnt++;
         else fail_cnt++;
         $display("txn %0d %s data %h chk %h: %s", n,
                  (stim_cmd[n].op == ECC_OP_DECODE) ? "decode" : "encode",
                  stim_cmd[n].data, stim_cmd[n].chk, (err_cnt == errs) ? "ok" : "FAILED");
         rng_state = xorshift32(rng_state);
         delay = int'(rng_state[2:0]);
         repeat (delay) @(posedge clk);
         @(posedge clk);
         #(DRIVE_DLY);
         ack_out = 1'b1;
         @(negedge clk);
         while (req_out) @(negedge clk);
         @(posedge clk);
         #(DRIVE_DLY);
         ack_out = 1'b0;
      end
   endtask

   // ack_in may only rise as an answer to req_in
   always @(negedge clk) begin
      if (rst_l && ack_in && !ack_in_prev && !req_in) begin
         $display("ack_in rose at %0t while req_in was low", $time);
         err_cnt++;
      end
      ack_in_prev = ack_in;
   end

   initial begin
      int limit;
      wait (stim_loaded === 1'b1);
      limit = num_vec * CYC_PER_VEC + 100;
      repeat (limit) @(posedge clk);
      $display("timeout after %0d cycles: only %0d of %0d responses arrived, responses are missing",
               limit, rsp_cnt, num_vec);
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial begin
      int errs;
      clk         = 1'b0;
      rst_l       = 1'b0;
      req_in      = 1'b0;
      ack_out     = 1'b0;
      cmd_op      = ECC_OP_ENCODE;
      cmd_data    = '0;
      cmd_chk     = '0;
      num_vec     = 0;
      rsp_cnt     = 0;
      pass_cnt    = 0;
      fail_cnt    = 0;
      err_cnt     = 0;
      ack_in_prev = 1'b0;
      rng_state   = 32'h6c2680a9;
      stim_loaded = 1'b0;
      load_stimulus();
      stim_loaded = 1'b1;

      errs = err_cnt;
      repeat (RESET_CYC) begin
         @(posedge clk);
         @(negedge clk);
         expect_reset_state();
      end
      @(posedge clk);
      #(DRIVE_DLY);
      rst_l = 1'b1;
      @(negedge clk);
      expect_reset_state();
      if (err_cnt == errs) pass_cnt++;
      else fail_cnt++;
      $display("reset: %s", (err_cnt == errs) ? "ok" : "FAILED");

      fork
         drive_commands();
         collect_responses();
      join

      // nothing more may come out once every command is answered
      repeat (DRAIN_CYC) begin
         @(negedge clk);
         if (req_out) begin
            $display("req_out high at %0t with no command outstanding", $time);
            err_cnt++;
         end
      end
      if (num_vec == 0) begin
         $display("no stimulus vectors were loaded");
      end
      $display("%0d tests, %0d passed, %0d failed, %0d check errors",
               pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
      if (err_cnt == 0 && fail_cnt == 0 && num_vec > 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* rtl/ecc_codec_top.sv */
`default_nettype none

module ecc_codec_top (
   input  logic               clk,
   input  logic               rst_l,
   input  logic               req_in,
   input  ecc_pkg::ecc_op_e   cmd_op,
   input  ecc_pkg::ecc_data_t cmd_data,
   input  ecc_pkg::ecc_chk_t  cmd_chk,
   output logic               ack_in,
   input  logic               ack_out,
   output logic               req_out,
   output ecc_pkg::ecc_data_t rsp_data,
   output ecc_pkg::ecc_chk_t  rsp_chk,
   output logic               rsp_single_err,
   output logic               rsp_double_err
);

   ecc_cmd_if cmd_if (.clk(clk));
   ecc_rsp_if rsp_if (.clk(clk));

   // sender handshake to internal valid/ready
   ecc_req_in i_req_in (
      .clk      (clk),
      .rst_l    (rst_l),
      .req_in   (req_in),
      .cmd_op   (cmd_op),
      .cmd_data (cmd_data),
      .cmd_chk  (cmd_chk),
      .ack_in   (ack_in),
      .cmd_o    (cmd_if.source)
   );

   ecc_engine i_engine (
      .clk   (clk),
      .rst_l (rst_l),
      .cmd_i (cmd_if.sink),
      .rsp_o (rsp_if.source)
   );

   // internal valid/ready to receiver handshake
   ecc_rsp_out i_rsp_out (
      .clk            (clk),
      .rst_l          (rst_l),
      .rsp_i          (rsp_if.sink),
      .ack_out        (ack_out),
      .req_out        (req_out),
      .rsp_data       (rsp_data),
      .rsp_chk        (rsp_chk),
      .rsp_single_err (rsp_single_err),
      .rsp_double_err (rsp_double_err)
   );

endmodule

`default_nettype wire

/* rtl/ecc_rsp_out.sv */
`default_nettype none

`include "ecc_config.svh"

module ecc_rsp_out (
   input  logic               clk,
   input  logic               rst_l,
   ecc_rsp_if.sink            rsp_i,
   input  logic               ack_out,
   output logic               req_out,
   output ecc_pkg::ecc_data_t rsp_data,
   output ecc_pkg::ecc_chk_t  rsp_chk,
   output logic               rsp_single_err,
   output logic               rsp_double_err
);
   import ecc_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_REQ,
      ST_WAIT
   } state_e;

   state_e                      state;
   logic [`ECC_SYNC_STAGES-1:0] ack_sync;
   logic                        ack_s;
   ecc_rsp_t                    hold_q;
   logic                        take;

   // ack_out arrives from the receiver's domain
   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         ack_sync <= '0;
      end else begin
         ack_sync <= {ack_sync[`ECC_SYNC_STAGES-2:0], ack_out};
      end
   end

   assign ack_s = ack_sync[`ECC_SYNC_STAGES-1];

   assign rsp_i.ready = (state == ST_IDLE);
   assign take        = rsp_i.valid && rsp_i.ready;

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE: if (take) state <= ST_REQ;
            ST_REQ:  if (ack_s) state <= ST_WAIT;
            // slot frees only after the receiver drops ack
            ST_WAIT: if (!ack_s) state <= ST_IDLE;
            default: state <= ST_IDLE;
         endcase
      end
   end

   // outputs read zero until the first response
   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         hold_q <= '0;
      end else if (take) begin
         hold_q <= rsp_i.rsp;
      end
   end

   assign req_out        = (state == ST_REQ) && !ack_s;
   assign rsp_data       = hold_q.data;
   assign rsp_chk        = hold_q.chk;
   assign rsp_single_err = hold_q.single_err;
   assign rsp_double_err = hold_q.double_err;

endmodule

`default_nettype wire

/* rtl/ecc_engine.sv */
`default_nettype none

`include "ecc_config.svh"

module ecc_engine (
   input  logic       clk,
   input  logic       rst_l,
   ecc_cmd_if.sink    cmd_i,
   ecc_rsp_if.source  rsp_o
);
   import ecc_pkg::*;

   ecc_chk_t               gen_chk;
   ecc_chk_t               fix_chk;
   ecc_chk_t               dec_chk;
   ecc_data_t              dec_data;
   ecc_syn_t               syn;
   logic                   parity_chk;
   logic                   data_err;
   logic [`ECC_CODE_W-1:0] code_rx;
   logic [`ECC_CODE_W-1:0] flip;
   logic [`ECC_CODE_W-1:0] code_fix;
   ecc_rsp_t               rsp_d;
   ecc_rsp_t               rsp_q;
   logic                   valid_q;
   logic                   load;

   // codeword index 0 is position 1
   function automatic logic [`ECC_CODE_W-1:0] to_code(ecc_data_t d, ecc_chk_t c);
      return {c[6], d[31:26], c[5], d[25:11], c[4], d[10:4], c[3], d[3:1],
              c[2], d[0], c[1:0]};
   endfunction

   function automatic ecc_data_t code_data(logic [`ECC_CODE_W-1:0] w);
      return {w[37:32], w[30:16], w[14:8], w[6:4], w[2]};
   endfunction

   function automatic ecc_chk_t code_chk(logic [`ECC_CODE_W-1:0] w);
      return {w[38], w[31], w[15], w[7], w[3], w[1:0]};
   endfunction

   ecc_checkgen i_cg_cmd (
      .data (cmd_i.cmd.data),
      .chk  (gen_chk)
   );

   // regenerates check bits once a data bit was corrected
   ecc_checkgen i_cg_fix (
      .data (dec_data),
      .chk  (fix_chk)
   );

   assign syn        = gen_chk[`ECC_CHK_W-2:0] ^ cmd_i.cmd.chk[`ECC_CHK_W-2:0];
   assign parity_chk = (^cmd_i.cmd.data) ^ (^cmd_i.cmd.chk);
   assign code_rx    = to_code(cmd_i.cmd.data, cmd_i.cmd.chk);

   // odd parity means one flipped bit; zero syndrome points at chk bit 6
   always_comb begin
      flip = '0;
      if (parity_chk) begin
         if (syn == '0) begin
            flip[`ECC_CODE_W-1] = 1'b1;
         end else if (syn < `ECC_CODE_W) begin
            flip[syn - 1'b1] = 1'b1;
         end
      end
   end

   assign code_fix = code_rx ^ flip;
   assign dec_data = code_data(code_fix);
   assign data_err = |code_data(flip);
   assign dec_chk  = data_err ? fix_chk : code_chk(code_fix);

   always_comb begin
      if (cmd_i.cmd.op == ECC_OP_ENCODE) begin
         rsp_d = '{data: cmd_i.cmd.data, chk: gen_chk, single_err: 1'b0, double_err: 1'b0};
      end else begin
         // even parity with nonzero syndrome is uncorrectable and leaves flip at zero
         rsp_d = '{data: dec_data, chk: dec_chk, single_err: parity_chk,
                   double_err: !parity_chk && (syn != '0)};
      end
   end

   // one result slot that refills in the cycle it drains
   assign load        = cmd_i.valid && cmd_i.ready;
   assign cmd_i.ready = !valid_q || rsp_o.ready;

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         valid_q <= 1'b0;
      end else if (load) begin
         valid_q <= 1'b1;
      end else if (rsp_o.ready) begin
         valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         rsp_q <= rsp_d;
      end
   end

   assign rsp_o.valid = valid_q;
   assign rsp_o.rsp   = rsp_q;

endmodule

`default_nettype wire

/* rtl/ecc_req_in.sv */
`default_nettype none

`include "ecc_config.svh"

module ecc_req_in (
   input  logic               clk,
   input  logic               rst_l,
   input  logic               req_in,
   input  ecc_pkg::ecc_op_e   cmd_op,
   input  ecc_pkg::ecc_data_t cmd_data,
   input  ecc_pkg::ecc_chk_t  cmd_chk,
   output logic               ack_in,
   ecc_cmd_if.source          cmd_o
);
   import ecc_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_OFFER,
      ST_ACK
   } state_e;

   state_e                      state;
   logic [`ECC_SYNC_STAGES-1:0] req_sync;
   logic                        req_s;
   ecc_cmd_t                    cmd_q;

   // req_in comes from the sender's clock domain
   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         req_sync <= '0;
      end else begin
         req_sync <= {req_sync[`ECC_SYNC_STAGES-2:0], req_in};
      end
   end

   assign req_s = req_sync[`ECC_SYNC_STAGES-1];

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE:  if (req_s) state <= ST_OFFER;
            ST_OFFER: if (cmd_o.ready) state <= ST_ACK;
            // hold here until the sender drops req
            ST_ACK:   if (!req_s) state <= ST_IDLE;
            default:  state <= ST_IDLE;
         endcase
      end
   end

   // sender keeps the command stable while req_in is high
   always_ff @(posedge clk) begin
      if (state == ST_IDLE && req_s) begin
         cmd_q <= '{op: cmd_op, data: cmd_data, chk: cmd_chk};
      end
   end

   assign cmd_o.valid = (state == ST_OFFER);
   assign cmd_o.cmd   = cmd_q;

   // drops together with the synchronized req
   assign ack_in = (state == ST_ACK) && req_s;

endmodule

`default_nettype wire

/* rtl/ecc_checkgen.sv */
`default_nettype none

`include "ecc_config.svh"

module ecc_checkgen (
   input  ecc_pkg::ecc_data_t data,
   output ecc_pkg::ecc_chk_t  chk
);
   import ecc_pkg::*;

   ecc_syn_t ham;

   // walk codeword positions 1..38, skipping the power-of-two slots
   // that hold the hamming bits themselves
   always_comb begin
      int unsigned d;
      ham = '0;
      d = 0;
      for (int unsigned p = 1; p < `ECC_CODE_W; p++) begin
         if ((p & (p - 1)) != 0) begin
            for (int k = 0; k < `ECC_CHK_W - 1; k++) begin
               if (p[k]) begin
                  ham[k] = ham[k] ^ data[d];
               end
            end
            d++;
         end
      end
   end

   // overall parity covers data and all six hamming bits
   assign chk = {(^data) ^ (^ham), ham};

endmodule

`default_nettype wire

/* rtl/ecc_pkg.sv */
`default_nettype none

`include "ecc_config.svh"

package ecc_pkg;

   typedef enum logic {
      ECC_OP_ENCODE = 1'b0,
      ECC_OP_DECODE = 1'b1
   } ecc_op_e;

   typedef logic [`ECC_DATA_W-1:0] ecc_data_t;

   // bits 0..5 hamming, bit 6 overall parity
   typedef logic [`ECC_CHK_W-1:0] ecc_chk_t;

   typedef logic [`ECC_CHK_W-2:0] ecc_syn_t;

   typedef struct packed {
      ecc_op_e   op;
      ecc_data_t data;
      ecc_chk_t  chk;
   } ecc_cmd_t;

   typedef struct packed {
      ecc_data_t data;
      ecc_chk_t  chk;
      logic      single_err;
      logic      double_err;
   } ecc_rsp_t;

endpackage

// command path from input side to engine
interface ecc_cmd_if (
   input logic clk
);
   import ecc_pkg::*;

   logic     valid;
   logic     ready;
   ecc_cmd_t cmd;

   modport source (input clk, output valid, output cmd, input ready);
   modport sink (input clk, input valid, input cmd, output ready);
endinterface

// response path from engine to output side
interface ecc_rsp_if (
   input logic clk
);
   import ecc_pkg::*;

   logic     valid;
   logic     ready;
   ecc_rsp_t rsp;

   modport source (input clk, output valid, output rsp, input ready);
   modport sink (input clk, input valid, input rsp, output ready);
endinterface

`default_nettype wire

/* rtl/ecc_config.svh */
`ifndef ECC_CONFIG_SVH
`define ECC_CONFIG_SVH

// data word width
`define ECC_DATA_W 32

// six hamming parities plus one overall parity
`define ECC_CHK_W 7

// codeword positions 1..39 holding data and check bits together
`define ECC_CODE_W 39

// flops in each handshake synchronizer
`define ECC_SYNC_STAGES 2

`endif
